// File: Bender.yml
package:
  name: mem_issue

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_issue_pkg.sv
      - rtl/mem_window_if.sv
      - rtl/mem_overlap_check.sv
      - rtl/mem_order_check.sv
      - rtl/mem_credit_counter.sv
      - rtl/mem_issue_select.sv
      - rtl/mem_issue_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/mem_issue_sva.sv
      - tests/mem_issue_tb.sv

// File: compile.f
+incdir+rtl
rtl/mem_issue_pkg.sv
rtl/mem_window_if.sv
rtl/mem_overlap_check.sv
rtl/mem_order_check.sv
rtl/mem_credit_counter.sv
rtl/mem_issue_select.sv
rtl/mem_issue_top.sv
tests/mem_issue_sva.sv
tests/mem_issue_tb.sv

// File: rtl/mem_credit_counter.sv
// free-credit register towards the memory units, spent by issue and refilled by returns
`timescale 1ns/1ps
`include "mem_issue_consts.svh"

module mem_credit_counter import mem_issue_pkg::*; (
	input logic clk,
	input logic rst_n,
	input credit_t grant_count,
	input logic credit_return,
	output credit_t credits
);

	// a return pulse is worth exactly one credit
	credit_t ret_inc;
	// count after this cycle's grants and return
	credit_t credits_nxt;

	assign ret_inc = {{(`CREDIT_W-1){1'b0}}, credit_return};

	// the selector never grants more than it holds, so the subtraction
	// cannot wrap, and the memory side never returns more than was spent
	assign credits_nxt = credits - grant_count + ret_inc;

	// ======================================================================
	// credit register
	// ======================================================================

	// a returned credit shows up in credits from the next cycle on
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// every memory unit is idle after reset
			credits <= credit_t'(`MEM_CREDITS);
		end else begin
			credits <= credits_nxt;
		end
	end

endmodule

// File: rtl/mem_issue_consts.svh
// sizes and limits of the memory issue scheduler, included by the package and by the RTL
`ifndef MEM_ISSUE_CONSTS_SVH
`define MEM_ISSUE_CONSTS_SVH

// ======================================================================
// window and address geometry
// ======================================================================

// number of the oldest queue entries looked at each cycle
`define WINDOW_SLOTS 8
// memory address width
`define ADDR_W 32
// byte-lane select width of one operation
`define SEL_W 23
// lanes from this bit upward are the extended lanes
`define EXT_SEL_LSB 16
// lowest address bit that is part of the cache-line number
`define LINE_LSB 4

// ======================================================================
// memory-unit flow control
// ======================================================================

// one credit per memory unit, all free after reset
`define MEM_CREDITS 2
// no more than this many operations start in one cycle
`define MAX_ISSUE 2
// wide enough for MEM_CREDITS and MAX_ISSUE
`define CREDIT_W 2

`endif

// File: rtl/mem_issue_pkg.sv
// shared types of the memory issue scheduler, imported by the RTL and by the testbench
`include "mem_issue_consts.svh"

package mem_issue_pkg;

	// ======================================================================
	// window types
	// ======================================================================

	// one bit per window slot, bit 0 is the oldest entry
	typedef logic [`WINDOW_SLOTS-1:0] slot_mask_t;

	// full memory address of an operation
	typedef logic [`ADDR_W-1:0] mem_addr_t;

	// byte-lane select, the upper lanes are the extended ones
	typedef logic [`SEL_W-1:0] byte_sel_t;

	// the cache-line number, i.e. the address without its offset bits
	typedef logic [`ADDR_W-`LINE_LSB-1:0] line_addr_t;

	// ======================================================================
	// flow-control types
	// ======================================================================

	// free credits, and also the number of operations issued in one cycle
	typedef logic [`CREDIT_W-1:0] credit_t;

endpackage

// File: rtl/mem_issue_select.sv
// oldest-first pick of the ready window slots, limited by credits and issue width, then registered
`timescale 1ns/1ps
`include "mem_issue_consts.svh"

module mem_issue_select import mem_issue_pkg::*; (
	input logic clk,
	input logic rst_n,
	mem_window_if.select win,
	input slot_mask_t overlap_ok,
	input slot_mask_t order_ok,
	input credit_t credits,
	output credit_t grant_count,
	output slot_mask_t issue_mask,
	output credit_t issue_count
);

	// slots that pass every check and could start this cycle
	slot_mask_t cand;
	// most grants allowed this cycle
	credit_t limit;
	// the combinational pick and its size
	slot_mask_t grant;
	credit_t count;

	// ======================================================================
	// candidates and grant limit
	// ======================================================================

	// address and data must be known, and a cancelled entry never goes
	assign cand = win.valid & win.memready & ~win.stomp & overlap_ok & order_ok;

	// the smaller of free credits and issue width
	assign limit = (credits < credit_t'(`MAX_ISSUE)) ? credits : credit_t'(`MAX_ISSUE);

	// ======================================================================
	// first-fit walk, oldest slot first
	// ======================================================================

	always_comb begin
		grant = '0;
		count = '0;
		for (int n = 0; n < `WINDOW_SLOTS; n++) begin
			// once the limit is reached the younger candidates wait
			if (cand[n] && (count < limit)) begin
				grant[n] = 1'b1;
				count = count + 1'b1;
			end
		end
	end

	// the counter spends credits for the pick made this cycle
	assign grant_count = count;

	// ======================================================================
	// registered issue mask
	// ======================================================================

	// issue_mask shows the pick made from the window sampled at the
	// previous edge, and issue_count always matches it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue_mask <= '0;
			issue_count <= '0;
		end else begin
			issue_mask <= grant;
			issue_count <= count;
		end
	end

endmodule

// File: rtl/mem_issue_top.sv
// top level of the memory issue scheduler, takes the age-ordered window and returns the issue mask
`timescale 1ns/1ps
`include "mem_issue_consts.svh"

module mem_issue_top import mem_issue_pkg::*; (
	input logic clk,
	input logic rst_n,
	// window status, slot 0 is the oldest entry
	input slot_mask_t slot_valid,
	input slot_mask_t slot_mem,
	input slot_mask_t slot_load,
	input slot_mask_t slot_store,
	input slot_mask_t slot_done,
	input slot_mask_t slot_out,
	input slot_mask_t slot_memready,
	input slot_mask_t slot_stomp,
	input slot_mask_t slot_acquire,
	input slot_mask_t slot_release,
	input slot_mask_t slot_flow_ctrl,
	input slot_mask_t slot_can_except,
	input mem_addr_t slot_addr [`WINDOW_SLOTS],
	input byte_sel_t slot_sel [`WINDOW_SLOTS],
	// write buffer still holds stores
	input logic wb_busy,
	// loads may pass unresolved branches and faulting ops
	input logic spec_load_en,
	// one pulse per memory unit that has become free
	input logic credit_return,
	output slot_mask_t issue_mask,
	output credit_t issue_count
);

	slot_mask_t overlap_ok;
	slot_mask_t order_ok;
	credit_t grant_count;
	credit_t credits;

	// ======================================================================
	// window bundle
	// ======================================================================

	mem_window_if win_if ();

	assign win_if.valid = slot_valid;
	assign win_if.mem = slot_mem;
	assign win_if.load = slot_load;
	assign win_if.store = slot_store;
	assign win_if.done = slot_done;
	assign win_if.out = slot_out;
	assign win_if.memready = slot_memready;
	assign win_if.stomp = slot_stomp;
	assign win_if.acquire = slot_acquire;
	assign win_if.release_op = slot_release;
	assign win_if.flow_ctrl = slot_flow_ctrl;
	assign win_if.can_except = slot_can_except;
	assign win_if.addr = slot_addr;
	assign win_if.sel = slot_sel;

	// ======================================================================
	// hazard checks, both combinational on the current window
	// ======================================================================

	mem_overlap_check overlap_i (
		.win(win_if.check),
		.overlap_ok(overlap_ok)
	);

	mem_order_check order_i (
		.win(win_if.check),
		.wb_busy(wb_busy),
		.spec_load_en(spec_load_en),
		.order_ok(order_ok)
	);

	// ======================================================================
	// selection and credits
	// ======================================================================

	mem_issue_select select_i (
		.clk(clk),
		.rst_n(rst_n),
		.win(win_if.select),
		.overlap_ok(overlap_ok),
		.order_ok(order_ok),
		.credits(credits),
		.grant_count(grant_count),
		.issue_mask(issue_mask),
		.issue_count(issue_count)
	);

	mem_credit_counter credit_i (
		.clk(clk),
		.rst_n(rst_n),
		.grant_count(grant_count),
		.credit_return(credit_return),
		.credits(credits)
	);

endmodule

// File: rtl/mem_order_check.sv
// acquire, release, write-buffer and store-speculation ordering of each window slot
`timescale 1ns/1ps
`include "mem_issue_consts.svh"

module mem_order_check import mem_issue_pkg::*; (
	mem_window_if.check win,
	input logic wb_busy,
	input logic spec_load_en,
	output slot_mask_t order_ok
);

	// prefix terms, bit n is set when some slot older than n has the property
	slot_mask_t older_acq;
	slot_mask_t older_mem;
	slot_mask_t older_store;
	slot_mask_t older_spec;

	// ======================================================================
	// prefix scan over the older slots
	// ======================================================================

	always_comb begin
		// nothing is older than slot 0
		older_acq = '0;
		older_mem = '0;
		older_store = '0;
		older_spec = '0;
		for (int n = 1; n < `WINDOW_SLOTS; n++) begin
			// a valid acquire holds back everything behind it
			older_acq[n] = older_acq[n-1] | (win.valid[n-1] & win.acquire[n-1]);
			// memory op that is valid and not yet done
			older_mem[n] = older_mem[n-1]
				| (win.valid[n-1] & win.mem[n-1] & ~win.done[n-1]);
			older_store[n] = older_store[n-1] | (win.valid[n-1] & win.store[n-1]);
			// an older branch or faulting op could still undo this slot
			older_spec[n] = older_spec[n-1]
				| (win.valid[n-1] & (win.flow_ctrl[n-1] | win.can_except[n-1]));
		end
	end

	// ======================================================================
	// per-slot ordering decision
	// ======================================================================

	always_comb begin
		logic rel_ok;
		logic wb_ok;
		logic spec_ok;

		for (int n = 0; n < `WINDOW_SLOTS; n++) begin
			// a release waits until all older memory ops have finished
			rel_ok = ~win.release_op[n] | ~older_mem[n];
			// a load must not pass buffered or older stores
			wb_ok = ~win.load[n] | (~wb_busy & ~older_store[n]);
			// loads may go speculatively when enabled, stores never do
			spec_ok = (win.load[n] & spec_load_en) | ~older_spec[n];
			order_ok[n] = ~older_acq[n] & rel_ok & wb_ok & spec_ok;
		end
	end

endmodule

// File: rtl/mem_overlap_check.sv
// address-overlap hazard of each window slot against all older slots, purely combinational
`timescale 1ns/1ps
`include "mem_issue_consts.svh"

module mem_overlap_check import mem_issue_pkg::*; (
	mem_window_if.check win,
	output slot_mask_t overlap_ok
);

	// cache-line number of each slot
	line_addr_t line [`WINDOW_SLOTS];
	// slot uses at least one extended byte lane
	slot_mask_t ext;
	// slot is a memory op that is still in flight or waiting to go
	slot_mask_t pend;

	// ======================================================================
	// per-slot terms
	// ======================================================================

	always_comb begin
		for (int i = 0; i < `WINDOW_SLOTS; i++) begin
			line[i] = win.addr[i][`ADDR_W-1:`LINE_LSB];
			// extended lanes are not tied to the line, so any use of them
			// has to be treated as a possible overlap
			ext[i] = |win.sel[i][`SEL_W-1:`EXT_SEL_LSB];
			pend[i] = win.valid[i] & win.mem[i] & ~win.done[i] & ~win.out[i];
		end
	end

	// ======================================================================
	// pairwise compare, slot n against every older slot m
	// ======================================================================

	always_comb begin
		logic sel_hit;
		logic line_hit;

		// slot 0 has nothing older and always passes
		overlap_ok = '1;
		for (int n = 1; n < `WINDOW_SLOTS; n++) begin
			for (int m = 0; m < n; m++) begin
				// shared byte lanes conflict whatever state the older slot is in
				sel_hit = |(win.sel[n] & win.sel[m]);
				// a pending older op conflicts on the same line, or whenever
				// either side reaches into the extended lanes
				line_hit = pend[m] & ((line[n] == line[m]) | ext[n] | ext[m]);
				// two loads can run in any order
				if ((sel_hit | line_hit) & ~(win.load[n] & win.load[m])) begin
					overlap_ok[n] = 1'b0;
				end
			end
		end
	end

endmodule

// File: rtl/mem_window_if.sv
// status of the window slots in age order, driven by the top level and read by checks and selector
`timescale 1ns/1ps
`include "mem_issue_consts.svh"

interface mem_window_if import mem_issue_pkg::*; ();

	// per-slot status flags, bit n belongs to slot n
	slot_mask_t valid;
	slot_mask_t mem;
	slot_mask_t load;
	slot_mask_t store;
	slot_mask_t done;
	slot_mask_t out;
	slot_mask_t memready;
	slot_mask_t stomp;
	slot_mask_t acquire;
	// release is a reserved word in the language, hence the suffix
	slot_mask_t release_op;
	slot_mask_t flow_ctrl;
	slot_mask_t can_except;

	// address and byte lanes of each slot
	mem_addr_t addr [`WINDOW_SLOTS];
	byte_sel_t sel [`WINDOW_SLOTS];

	// the top level fills every field from its ports
	modport source (
		output valid, mem, load, store, done, out, memready, stomp,
		output acquire, release_op, flow_ctrl, can_except, addr, sel
	);

	// the hazard checks see everything about a slot except its readiness
	modport check (
		input valid, mem, load, store, done, out,
		input acquire, release_op, flow_ctrl, can_except, addr, sel
	);

	// the selector only needs to know which slots could start at all
	modport select (
		input valid, memready, stomp
	);

endinterface

// File: tests/mem_issue_sva.sv
// assertions on the scheduler top level, attached to every mem_issue_top by the bind below
`timescale 1ns/1ps
`include "mem_issue_consts.svh"

module mem_issue_sva import mem_issue_pkg::*; (
	input logic clk,
	input logic rst_n,
	input slot_mask_t slot_valid,
	input slot_mask_t issue_mask,
	input credit_t issue_count,
	input credit_t credits
);

	// ======================================================================
	// credit and issue properties
	// ======================================================================

	// a return beyond the spent credits would push the count over the unit count
	assert property (@(posedge clk) disable iff (!rst_n) credits <= credit_t'(`MEM_CREDITS))
		else $error("free credits exceed the number of memory units");

	assert property (@(posedge clk) disable iff (!rst_n) issue_count == $countones(issue_mask))
		else $error("issue_count does not match the bits set in issue_mask");

	assert property (@(posedge clk) !rst_n |-> issue_mask == '0)
		else $error("issue_mask is not clear during reset");

	// the mask belongs to the window sampled one edge earlier
	assert property (@(posedge clk) disable iff (!rst_n) (issue_mask & ~$past(slot_valid)) == '0)
		else $error("issue_mask marks a slot that was not valid");

endmodule

bind mem_issue_top mem_issue_sva sva_i (
	.clk(clk),
	.rst_n(rst_n),
	.slot_valid(slot_valid),
	.issue_mask(issue_mask),
	.issue_count(issue_count),
	.credits(credits)
);

// File: tests/mem_issue_tb.sv
// directed testbench of the memory issue scheduler, run from compile.f with mem_issue_tb as top
`timescale 1ns/1ps
`include "mem_issue_consts.svh"

module mem_issue_tb import mem_issue_pkg::*; ();

	// more than four times the cycles that all tests take together
	localparam int TIMEOUT_CYCLES = 400;

	logic clk;
	logic rst_n;
	slot_mask_t slot_valid, slot_mem, slot_load, slot_store, slot_done, slot_out;
	slot_mask_t slot_memready, slot_stomp, slot_acquire, slot_release;
	slot_mask_t slot_flow_ctrl, slot_can_except;
	mem_addr_t slot_addr [`WINDOW_SLOTS];
	byte_sel_t slot_sel [`WINDOW_SLOTS];
	logic wb_busy;
	logic spec_load_en;
	logic credit_return;
	slot_mask_t issue_mask;
	credit_t issue_count;

	// free credits as the credit rule predicts them
	int credits_exp;
	int cycle_count = 0;
	integer seed;
	mem_addr_t base_addr;
	string test_name;

	mem_issue_top dut_i (.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout in %s, the run took longer than %0d cycles", test_name, TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1, "run stopped on timeout");
		end
	end

	// ======================================================================
	// window helpers
	// ======================================================================

	// address in cache line k, lines with different k never match
	function automatic mem_addr_t line_of(input logic [3:0] k, input logic [3:0] offs);
		return {base_addr[`ADDR_W-1:8], k, offs};
	endfunction

	function automatic byte_sel_t lane(input int k);
		return byte_sel_t'(1) << k;
	endfunction

	task automatic clear_window();
		for (int i = 0; i < `WINDOW_SLOTS; i++) begin
			slot_addr[i] <= '0;
			slot_sel[i] <= '0;
		end
		{slot_valid, slot_mem, slot_load, slot_store, slot_done, slot_out} <= '0;
		{slot_memready, slot_stomp, slot_acquire, slot_release} <= '0;
		{slot_flow_ctrl, slot_can_except} <= '0;
		wb_busy <= 1'b0;
		spec_load_en <= 1'b0;
	endtask

	// a ready memory op, a load when is_load is set and a store otherwise
	task automatic put_op(input int s, input bit is_load, input mem_addr_t a, input byte_sel_t b);
		slot_valid[s] <= 1'b1;
		slot_mem[s] <= 1'b1;
		slot_memready[s] <= 1'b1;
		slot_load[s] <= is_load;
		slot_store[s] <= !is_load;
		slot_addr[s] <= a;
		slot_sel[s] <= b;
	endtask

	// a valid branch entry, not a memory op
	task automatic put_branch(input int s);
		slot_valid[s] <= 1'b1;
		slot_flow_ctrl[s] <= 1'b1;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("CHECK FAILED %s in %s expected %h got %h", name, test_name, exp, got);
			$display("SOME TESTS FAILED");
			$fatal(1, "run stopped at first error");
		end
	endtask

	// every registered grant spends its credits in the prediction
	task automatic check_issue(input slot_mask_t exp_mask, input int exp_count);
		check_value("issue_mask", 32'(exp_mask), 32'(issue_mask));
		check_value("issue_count", exp_count, 32'(issue_count));
		credits_exp = credits_exp - exp_count;
	endtask

	// one credit comes back at each edge that samples credit_return high
	task automatic return_credits(input int n);
		repeat (n) begin
			@(posedge clk);
			credit_return <= 1'b1;
		end
		@(posedge clk);
		credit_return <= 1'b0;
		credits_exp = credits_exp + n;
	endtask

	// the window set up after open_case is seen for exactly one cycle
	task automatic open_case();
		@(posedge clk);
		clear_window();
	endtask

	task automatic close_case(input slot_mask_t exp_mask, input int exp_count);
		@(posedge clk);
		clear_window();
		@(negedge clk);
		check_issue(exp_mask, exp_count);
		if (credits_exp < `MEM_CREDITS)
			return_credits(`MEM_CREDITS - credits_exp);
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================

	task automatic reset_and_single_issue();
		test_name = "reset and single issue";
		@(negedge clk);
		check_issue('0, 0);
		open_case();
		put_op(0, 1, line_of(1, 0), lane(0));
		close_case(8'h01, 1);
	endtask

	task automatic credit_backpressure();
		test_name = "credits and width";
		open_case();
		put_op(0, 1, line_of(1, 0), lane(0));
		put_op(1, 1, line_of(2, 0), lane(1));
		put_op(2, 1, line_of(3, 0), lane(2));
		// slots 0 and 1 issue and retire, slot 2 stays pending
		@(posedge clk);
		slot_valid[1:0] <= 2'b00;
		@(negedge clk);
		check_issue(8'h03, 2);
		@(posedge clk);
		@(negedge clk);
		check_issue('0, 0);
		@(posedge clk);
		credit_return <= 1'b1;
		@(negedge clk);
		check_issue('0, 0);
		// the return is sampled here and is usable from this cycle on
		@(posedge clk);
		credit_return <= 1'b0;
		credits_exp = credits_exp + 1;
		@(negedge clk);
		check_issue('0, 0);
		close_case(8'h04, 1);
	endtask

	task automatic address_overlap();
		test_name = "address overlap";
		open_case();
		put_op(0, 0, line_of(4, 0), lane(0));
		put_op(1, 1, line_of(4, 8), lane(1));
		close_case(8'h01, 1);
		// a store behind a pending load on the same line waits
		open_case();
		put_op(0, 1, line_of(4, 0), lane(0));
		put_op(1, 0, line_of(4, 8), lane(1));
		close_case(8'h01, 1);
		// loads to one line never conflict
		open_case();
		put_op(0, 1, line_of(4, 0), lane(0));
		put_op(1, 1, line_of(4, 8), lane(1));
		close_case(8'h03, 2);
		open_case();
		put_op(0, 0, line_of(5, 0), lane(3));
		put_op(1, 0, line_of(6, 0), lane(3));
		close_case(8'h01, 1);
		open_case();
		put_op(0, 0, line_of(5, 0), lane(3));
		put_op(1, 0, line_of(6, 0), lane(4));
		close_case(8'h03, 2);
		// an extended lane conflicts with a pending op on any line
		open_case();
		put_op(0, 0, line_of(5, 0), lane(0));
		put_op(1, 0, line_of(6, 0), lane(`EXT_SEL_LSB));
		close_case(8'h01, 1);
	endtask

	task automatic acquire_release();
		test_name = "acquire and release";
		open_case();
		put_op(0, 1, line_of(7, 0), lane(0));
		slot_acquire[0] <= 1'b1;
		put_op(1, 1, line_of(8, 0), lane(1));
		close_case(8'h01, 1);
		open_case();
		put_op(0, 1, line_of(9, 0), lane(0));
		put_op(1, 1, line_of(10, 0), lane(1));
		put_op(2, 0, line_of(11, 0), lane(2));
		slot_release[2] <= 1'b1;
		// the two loads go out but are not done yet
		@(posedge clk);
		slot_out[1:0] <= 2'b11;
		slot_memready[1:0] <= 2'b00;
		@(negedge clk);
		check_issue(8'h03, 2);
		return_credits(2);
		@(posedge clk);
		slot_done[1:0] <= 2'b11;
		@(negedge clk);
		check_issue('0, 0);
		close_case(8'h04, 1);
	endtask

	task automatic buffer_and_speculation();
		test_name = "write buffer and speculation";
		open_case();
		put_op(0, 1, line_of(12, 0), lane(0));
		wb_busy <= 1'b1;
		close_case('0, 0);
		open_case();
		put_op(0, 0, line_of(13, 0), lane(0));
		put_op(1, 1, line_of(14, 0), lane(1));
		close_case(8'h01, 1);
		// stores stay behind the branch even with speculative loads on
		open_case();
		put_branch(0);
		put_op(1, 0, line_of(15, 0), lane(1));
		spec_load_en <= 1'b1;
		close_case('0, 0);
		open_case();
		put_branch(0);
		put_op(1, 1, line_of(1, 0), lane(1));
		close_case('0, 0);
		open_case();
		put_branch(0);
		put_op(1, 1, line_of(1, 0), lane(1));
		spec_load_en <= 1'b1;
		close_case(8'h02, 1);
		// a cancelled entry never goes, the next ready one does
		open_case();
		put_op(0, 1, line_of(2, 0), lane(0));
		slot_stomp[0] <= 1'b1;
		put_op(1, 1, line_of(3, 0), lane(1));
		close_case(8'h02, 1);
	endtask

	initial begin
		seed = 32'h2f71;
		base_addr = $random(seed);
		test_name = "reset";
		clk = 1'b0;
		rst_n = 1'b0;
		credit_return = 1'b0;
		clear_window();
		credits_exp = `MEM_CREDITS;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		reset_and_single_issue();
		credit_backpressure();
		address_overlap();
		acquire_release();
		buffer_and_speculation();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
